//--- hdl/rv_ex_pkg.sv
`default_nettype none

package rv_ex_pkg;

    localparam int xlen      = 32;
    localparam int ir_type_w = 4;

    // Instruction classes from decode
    localparam logic [ir_type_w-1:0] lui_ir     = 4'd0;
    localparam logic [ir_type_w-1:0] auipc_ir   = 4'd1;
    localparam logic [ir_type_w-1:0] jal_ir     = 4'd2;
    localparam logic [ir_type_w-1:0] jalr_ir    = 4'd3;
    localparam logic [ir_type_w-1:0] branch_ir  = 4'd4;
    localparam logic [ir_type_w-1:0] load_ir    = 4'd5;
    localparam logic [ir_type_w-1:0] store_ir   = 4'd6;
    localparam logic [ir_type_w-1:0] reg_imm_ir = 4'd7;
    localparam logic [ir_type_w-1:0] reg_reg_ir = 4'd8;

    // OP and OP-IMM funct3 field
    localparam logic [2:0] add_funct3  = 3'b000;
    localparam logic [2:0] sll_funct3  = 3'b001;
    localparam logic [2:0] slt_funct3  = 3'b010;
    localparam logic [2:0] sltu_funct3 = 3'b011;
    localparam logic [2:0] xor_funct3  = 3'b100;
    localparam logic [2:0] sr_funct3   = 3'b101;
    localparam logic [2:0] or_funct3   = 3'b110;
    localparam logic [2:0] and_funct3  = 3'b111;

    // ALU ops, funct7[5] over funct3
    localparam logic [3:0] alu_add  = {1'b0, add_funct3};
    localparam logic [3:0] alu_sub  = {1'b1, add_funct3};
    localparam logic [3:0] alu_sll  = {1'b0, sll_funct3};
    localparam logic [3:0] alu_slt  = {1'b0, slt_funct3};
    localparam logic [3:0] alu_sltu = {1'b0, sltu_funct3};
    localparam logic [3:0] alu_xor  = {1'b0, xor_funct3};
    localparam logic [3:0] alu_srl  = {1'b0, sr_funct3};
    localparam logic [3:0] alu_sra  = {1'b1, sr_funct3};
    localparam logic [3:0] alu_or   = {1'b0, or_funct3};
    localparam logic [3:0] alu_and  = {1'b0, and_funct3};

    // Codes outside the funct space
    localparam logic [3:0] alu_cp_in2 = 4'b1001;
    localparam logic [3:0] alu_jalr   = 4'b1010;

    // Branch ops, equal to funct3 for conditional branches
    localparam logic [2:0] br_beq     = 3'b000;
    localparam logic [2:0] br_bne     = 3'b001;
    localparam logic [2:0] br_jump    = 3'b010;
    localparam logic [2:0] br_no_jump = 3'b011;
    localparam logic [2:0] br_blt     = 3'b100;
    localparam logic [2:0] br_bge     = 3'b101;
    localparam logic [2:0] br_bltu    = 3'b110;
    localparam logic [2:0] br_bgeu    = 3'b111;

endpackage

`default_nettype wire

//--- hdl/ex_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl (
    input  logic [rv_ex_pkg::ir_type_w-1:0] ir_type,
    input  logic [2:0]                      funct3,
    input  logic [6:0]                      funct7,
    input  logic [rv_ex_pkg::xlen-1:0]      data1,
    input  logic [rv_ex_pkg::xlen-1:0]      data2,
    input  logic [rv_ex_pkg::xlen-1:0]      pc,
    input  logic [rv_ex_pkg::xlen-1:0]      imm,
    output logic [rv_ex_pkg::xlen-1:0]      in1,
    output logic [rv_ex_pkg::xlen-1:0]      in2,
    output logic [3:0]                      alu_op,
    output logic [2:0]                      branch_op,
    output logic                            link
);

    logic [3:0] arith_op;

    // Arithmetic op from funct fields
    always_comb
    begin
        case (funct3)
            rv_ex_pkg::add_funct3:
            begin
                // addi has no sub form
                if (ir_type == rv_ex_pkg::reg_imm_ir)
                    arith_op = {1'b0, funct3};
                else
                    arith_op = {funct7[5], funct3};
            end
            rv_ex_pkg::sr_funct3:   arith_op = {funct7[5], funct3};
            rv_ex_pkg::sll_funct3:  arith_op = {1'b0, funct3};
            rv_ex_pkg::slt_funct3:  arith_op = {1'b0, funct3};
            rv_ex_pkg::sltu_funct3: arith_op = {1'b0, funct3};
            rv_ex_pkg::xor_funct3:  arith_op = {1'b0, funct3};
            rv_ex_pkg::or_funct3:   arith_op = {1'b0, funct3};
            rv_ex_pkg::and_funct3:  arith_op = {1'b0, funct3};
            default:                arith_op = rv_ex_pkg::alu_add;
        endcase
    end

    always_comb
    begin
        in1       = data1;
        in2       = imm;
        alu_op    = rv_ex_pkg::alu_add;
        branch_op = rv_ex_pkg::br_no_jump;
        link      = 1'b0;
        case (ir_type)
            rv_ex_pkg::lui_ir:
            begin
                in1    = pc;
                alu_op = rv_ex_pkg::alu_cp_in2;
            end
            rv_ex_pkg::auipc_ir:
            begin
                in1 = pc;
            end
            rv_ex_pkg::jal_ir:
            begin
                in1       = pc;
                branch_op = rv_ex_pkg::br_jump;
                link      = 1'b1;
            end
            rv_ex_pkg::jalr_ir:
            begin
                alu_op    = rv_ex_pkg::alu_jalr;
                branch_op = rv_ex_pkg::br_jump;
                link      = 1'b1;
            end
            rv_ex_pkg::branch_ir:
            begin
                // Target is pc + imm, condition from funct3
                in1       = pc;
                branch_op = funct3;
            end
            rv_ex_pkg::reg_imm_ir:
            begin
                alu_op = arith_op;
            end
            rv_ex_pkg::reg_reg_ir:
            begin
                in2    = data2;
                alu_op = arith_op;
            end
            // Load, store and unknown classes keep address add
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_ex_pkg::xlen-1:0] in1,
    input  logic [rv_ex_pkg::xlen-1:0] in2,
    input  logic [3:0]                 alu_op,
    output logic [rv_ex_pkg::xlen-1:0] alu_result
);

    logic [rv_ex_pkg::xlen-1:0] sum;
    logic [4:0]                 shamt;
    logic                       lt_signed;
    logic                       lt_unsigned;

    assign sum         = in1 + in2;
    assign shamt       = in2[4:0];
    assign lt_signed   = $signed(in1) < $signed(in2);
    assign lt_unsigned = in1 < in2;

    always_comb
    begin
        case (alu_op)
            rv_ex_pkg::alu_add:    alu_result = sum;
            rv_ex_pkg::alu_sub:    alu_result = in1 - in2;
            rv_ex_pkg::alu_sll:    alu_result = in1 << shamt;
            rv_ex_pkg::alu_slt:
                alu_result = {{(rv_ex_pkg::xlen-1){1'b0}}, lt_signed};
            rv_ex_pkg::alu_sltu:
                alu_result = {{(rv_ex_pkg::xlen-1){1'b0}}, lt_unsigned};
            rv_ex_pkg::alu_xor:    alu_result = in1 ^ in2;
            rv_ex_pkg::alu_srl:    alu_result = in1 >> shamt;
            rv_ex_pkg::alu_sra:    alu_result = $unsigned($signed(in1) >>> shamt);
            rv_ex_pkg::alu_or:     alu_result = in1 | in2;
            rv_ex_pkg::alu_and:    alu_result = in1 & in2;
            rv_ex_pkg::alu_cp_in2: alu_result = in2;
            // jalr clears the low bit of the target
            rv_ex_pkg::alu_jalr:   alu_result = {sum[rv_ex_pkg::xlen-1:1], 1'b0};
            default:               alu_result = sum;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic [rv_ex_pkg::xlen-1:0] data1,
    input  logic [rv_ex_pkg::xlen-1:0] data2,
    input  logic [2:0]                 branch_op,
    output logic                       taken
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = data1 == data2;
    assign lt  = $signed(data1) < $signed(data2);
    assign ltu = data1 < data2;

    always_comb
    begin
        case (branch_op)
            rv_ex_pkg::br_beq:     taken = eq;
            rv_ex_pkg::br_bne:     taken = !eq;
            rv_ex_pkg::br_blt:     taken = lt;
            rv_ex_pkg::br_bge:     taken = !lt;
            rv_ex_pkg::br_bltu:    taken = ltu;
            rv_ex_pkg::br_bgeu:    taken = !ltu;
            rv_ex_pkg::br_jump:    taken = 1'b1;
            rv_ex_pkg::br_no_jump: taken = 1'b0;
            default:               taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/ex_result.sv
`timescale 1ns/1ps
`default_nettype none

module ex_result (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic [rv_ex_pkg::xlen-1:0] pc,
    input  logic                       link,
    input  logic [rv_ex_pkg::xlen-1:0] alu_result,
    input  logic                       taken,
    output logic                       out_valid,
    output logic [rv_ex_pkg::xlen-1:0] rd_value,
    output logic                       jump_taken,
    output logic [rv_ex_pkg::xlen-1:0] jump_target
);

    logic [rv_ex_pkg::xlen-1:0] link_value;
    logic [rv_ex_pkg::xlen-1:0] rd_next;

    // Return address for jal and jalr
    assign link_value = pc + rv_ex_pkg::xlen'(4);
    assign rd_next    = link ? link_value : alu_result;

    // One pulse per accepted instruction
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // Results hold between strobes
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_value    <= '0;
            jump_taken  <= 1'b0;
            jump_target <= '0;
        end
        else if (in_valid)
        begin
            rd_value    <= rd_next;
            jump_taken  <= taken;
            jump_target <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [rv_ex_pkg::ir_type_w-1:0] ir_type,
    input  logic [2:0]                      funct3,
    input  logic [6:0]                      funct7,
    input  logic [rv_ex_pkg::xlen-1:0]      data1,
    input  logic [rv_ex_pkg::xlen-1:0]      data2,
    input  logic [rv_ex_pkg::xlen-1:0]      pc,
    input  logic [rv_ex_pkg::xlen-1:0]      imm,
    output logic                            out_valid,
    output logic [rv_ex_pkg::xlen-1:0]      rd_value,
    output logic                            jump_taken,
    output logic [rv_ex_pkg::xlen-1:0]      jump_target
);

    logic [rv_ex_pkg::xlen-1:0] in1;
    logic [rv_ex_pkg::xlen-1:0] in2;
    logic [3:0]                 alu_op;
    logic [2:0]                 branch_op;
    logic                       link;
    logic [rv_ex_pkg::xlen-1:0] alu_result;
    logic                       taken;

    ex_ctrl u_ctrl (
        .ir_type   (ir_type),
        .funct3    (funct3),
        .funct7    (funct7),
        .data1     (data1),
        .data2     (data2),
        .pc        (pc),
        .imm       (imm),
        .in1       (in1),
        .in2       (in2),
        .alu_op    (alu_op),
        .branch_op (branch_op),
        .link      (link)
    );

    alu u_alu (
        .in1        (in1),
        .in2        (in2),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    // Compares register values, not the ALU operands
    branch_unit u_branch (
        .data1     (data1),
        .data2     (data2),
        .branch_op (branch_op),
        .taken     (taken)
    );

    ex_result u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .pc          (pc),
        .link        (link),
        .alu_result  (alu_result),
        .taken       (taken),
        .out_valid   (out_valid),
        .rd_value    (rd_value),
        .jump_taken  (jump_taken),
        .jump_target (jump_target)
    );

endmodule

`default_nettype wire

//--- tests/ex_stage_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_properties (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            in_valid,
    input logic [rv_ex_pkg::ir_type_w-1:0] ir_type,
    input logic [rv_ex_pkg::xlen-1:0]      pc,
    input logic [rv_ex_pkg::xlen-1:0]      imm,
    input logic                            out_valid,
    input logic [rv_ex_pkg::xlen-1:0]      rd_value,
    input logic                            jump_taken,
    input logic [rv_ex_pkg::xlen-1:0]      jump_target
);

    // One cycle of latency, one pulse per strobe
    assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid by one cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && ir_type == rv_ex_pkg::jal_ir |=>
            jump_taken && rd_value == $past(pc) + 32'd4)
        else $error("jal did not take the jump or link pc plus 4");

    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && ir_type == rv_ex_pkg::lui_ir |=> rd_value == $past(imm))
        else $error("lui result differs from the immediate");

    // Outputs hold between results
    assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> $stable(rd_value) && $stable(jump_taken) && $stable(jump_target))
        else $error("stage output changed without out_valid");

endmodule

bind ex_stage ex_stage_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .ir_type     (ir_type),
    .pc          (pc),
    .imm         (imm),
    .out_valid   (out_valid),
    .rd_value    (rd_value),
    .jump_taken  (jump_taken),
    .jump_target (jump_target)
);

`default_nettype wire

//--- tests/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

    localparam int n_instr     = 4 + 64 + 32 + 30 + 16;
    localparam int watchdog_ns = n_instr * 20 * 4 + 10 * 20;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [3:0]  ir_type;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] data1;
    logic [31:0] data2;
    logic [31:0] pc;
    logic [31:0] imm;
    logic        out_valid;
    logic [31:0] rd_value;
    logic        jump_taken;
    logic [31:0] jump_target;

    // {taken, rd, target} for each instruction in flight
    logic [64:0] expected[$];
    logic [64:0] head;
    logic [31:0] r;
    logic [63:0] pair;
    int          errors;
    int          err_mark;
    int          passed;
    int          failed;

    ex_stage u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout after %0d ns, the tests did not complete", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Mismatch %s: expected %h, got %h", name, exp, act);
        errors++;
    endtask

    task automatic complain(input string what);
        $display("Error: %s", what);
        errors++;
    endtask

    // Expected outputs from the RV32I rules
    function automatic logic [64:0] model_result(input logic [3:0] t, input logic [2:0] f3,
        input logic [6:0] f7, input logic [31:0] d1, input logic [31:0] d2,
        input logic [31:0] p, input logic [31:0] im);
        logic [31:0] b;
        logic [31:0] res;
        logic        alt;
        logic        tk;
        b   = (t == rv_ex_pkg::reg_reg_ir) ? d2 : im;
        // addi has no sub form and srai keeps its funct7 bit
        alt = f7[5] && (t == rv_ex_pkg::reg_reg_ir || f3 != 3'd0);
        tk  = 1'b0;
        case (t)
            rv_ex_pkg::lui_ir:   res = im;
            rv_ex_pkg::auipc_ir,
            rv_ex_pkg::jal_ir:   res = p + im;
            rv_ex_pkg::jalr_ir:  res = (d1 + im) & ~32'd1;
            rv_ex_pkg::branch_ir:
            begin
                res = p + im;
                case (f3)
                    3'd0:    tk = d1 == d2;
                    3'd1:    tk = d1 != d2;
                    3'd4:    tk = $signed(d1) < $signed(d2);
                    3'd5:    tk = $signed(d1) >= $signed(d2);
                    3'd6:    tk = d1 < d2;
                    default: tk = d1 >= d2;
                endcase
            end
            rv_ex_pkg::reg_imm_ir,
            rv_ex_pkg::reg_reg_ir:
                case (f3)
                    3'd0:    res = alt ? d1 - b : d1 + b;
                    3'd1:    res = d1 << b[4:0];
                    3'd2:    res = {31'd0, $signed(d1) < $signed(b)};
                    3'd3:    res = {31'd0, d1 < b};
                    3'd4:    res = d1 ^ b;
                    3'd5:
                        if (alt)
                            res = $signed(d1) >>> b[4:0];
                        else
                            res = d1 >> b[4:0];
                    3'd6:    res = d1 | b;
                    default: res = d1 & b;
                endcase
            default:             res = d1 + im;
        endcase
        if (t == rv_ex_pkg::jal_ir || t == rv_ex_pkg::jalr_ir)
            model_result = {1'b1, p + 32'd4, res};
        else
            model_result = {tk, res, res};
    endfunction

    task automatic drive_instr(input logic [3:0] t, input logic [2:0] f3, input logic [6:0] f7,
                               input logic [31:0] d1, input logic [31:0] d2,
                               input logic [31:0] p, input logic [31:0] im);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        ir_type  = t;
        funct3   = f3;
        funct7   = f7;
        data1    = d1;
        data2    = d2;
        pc       = p;
        imm      = im;
        expected.push_back(model_result(t, f3, f7, d1, d2, p, im));
    endtask

    task automatic random_instr(input logic [3:0] t);
        drive_instr(t, 3'($urandom), 7'($urandom), $urandom, $urandom, $urandom, $urandom);
    endtask

    // Strobe low with fresh values on the other inputs
    task automatic idle_inputs();
        in_valid = 1'b0;
        ir_type  = 4'($urandom);
        funct3   = 3'($urandom);
        funct7   = 7'($urandom);
        data1    = $urandom;
        data2    = $urandom;
        pc       = $urandom;
        imm      = $urandom;
    endtask

    // Drop the strobe and report once the last results are in
    task automatic close_test(input string name);
        @(posedge clk);
        #1 idle_inputs();
        for (int n = 0; n < 3 && expected.size() != 0; n++)
            @(posedge clk);
        if (expected.size() != 0)
            complain("out_valid missing for an issued instruction");
        expected.delete();
        if (errors == err_mark)
            passed++;
        else
            failed++;
        $display("Test %s done with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (out_valid && expected.size() == 0)
            complain("out_valid pulsed with no instruction pending");
        else if (out_valid)
        begin
            head = expected.pop_front();
            assert (jump_taken == head[64])
                else mismatch("jump_taken", {31'd0, head[64]}, {31'd0, jump_taken});
            assert (rd_value == head[63:32])
                else mismatch("rd_value", head[63:32], rd_value);
            assert (jump_target == head[31:0])
                else mismatch("jump_target", head[31:0], jump_target);
        end
    end

    initial
    begin
        void'($urandom(32'h6bfcf173));
        {in_valid, ir_type, funct3, funct7} = '0;
        {data1, data2, pc, imm} = '0;
        errors   = 0;
        err_mark = 0;
        passed   = 0;
        failed   = 0;
        rst_n    = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        // Quiet cycles, back-to-back strobes, then a gap
        repeat (3) @(posedge clk);
        repeat (3) random_instr(rv_ex_pkg::lui_ir);
        @(posedge clk);
        #1 idle_inputs();
        random_instr(rv_ex_pkg::lui_ir);
        close_test("reset_timing");

        for (int f = 0; f < 8; f++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                drive_instr(rv_ex_pkg::reg_reg_ir, 3'(f), {1'b0, k[0], 5'd0},
                            $urandom, $urandom, $urandom, $urandom);
                drive_instr(rv_ex_pkg::reg_imm_ir, 3'(f), 7'($urandom),
                            $urandom, $urandom, $urandom, $urandom);
            end
        end
        close_test("arithmetic");

        for (int i = 0; i < 8; i++)
        begin
            random_instr(rv_ex_pkg::lui_ir);
            random_instr(rv_ex_pkg::auipc_ir);
            random_instr(rv_ex_pkg::load_ir);
            random_instr(rv_ex_pkg::store_ir);
        end
        close_test("upper_and_address");

        for (int f = 0; f < 8; f++)
        begin
            for (int c = 0; c < 5; c++)
            begin
                r = $urandom & 32'h7fff_ffff;
                case (c)
                    0:       pair = {r, r};
                    1:       pair = {r, r + 32'd5};
                    2:       pair = {r + 32'd5, r};
                    3:       pair = {r | 32'h8000_0000, r};
                    default: pair = {r, r | 32'h8000_0000};
                endcase
                // funct3 2 and 3 are not branch conditions
                if (f != 2 && f != 3)
                    drive_instr(rv_ex_pkg::branch_ir, 3'(f), 7'($urandom),
                                pair[63:32], pair[31:0], $urandom, $urandom);
            end
        end
        close_test("branches");

        for (int i = 0; i < 8; i++)
        begin
            random_instr(rv_ex_pkg::jal_ir);
            random_instr(rv_ex_pkg::jalr_ir);
        end
        close_test("jumps");

        $display("Tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0 && errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hdl/rv_ex_pkg.sv
hdl/ex_ctrl.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/ex_result.sv
hdl/ex_stage.sv
tests/ex_stage_properties.sv
tests/ex_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ex_stage_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
